//--- Bender.yml
package:
  name: weight_manager

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wm_types_pkg.sv
      - wm_instr_pkg.sv
      - wm_instr_decode.sv
      - wm_weight_row.sv
      - wm_read_port.sv
      - weight_manager.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_weight_manager.sv

# Simulation top is tb_weight_manager, design top is weight_manager

//--- flist.f
+incdir+.
wm_types_pkg.sv
wm_instr_pkg.sv
wm_instr_decode.sv
wm_weight_row.sv
wm_read_port.sv
weight_manager.sv
tb_weight_manager.sv

//--- tb_weight_manager.sv
`timescale 1ns/1ps
`include "wm_cfg.svh"

module tb_weight_manager;

    import wm_types_pkg::*;
    import wm_instr_pkg::*;

    localparam int W     = `WM_WIDTH;
    localparam int D     = `WM_DEPTH;
    localparam int WB    = `WM_BITWIDTH;
    localparam int WMAX  = 2**(WB-1) - 1;
    localparam int WMIN  = -(2**(WB-1));
    localparam int CELLS = W * D;

    localparam int RST_CYCLES = 5;
    localparam int INC_ROUNDS = 6;
    localparam int B2B_CMDS   = 96;
    localparam int RESET_LEN  = RST_CYCLES + 4;
    localparam int LOAD_LEN   = CELLS * 3 + CELLS + 6;
    localparam int INC_LEN    = INC_ROUNDS * 4 + 4;
    localparam int SAT_LEN    = 2 * W + 12;
    localparam int B2B_LEN    = B2B_CMDS + 6;
    localparam int TIMEOUT_CYCLES = RESET_LEN + LOAD_LEN + INC_LEN + SAT_LEN + B2B_LEN + 50;

    logic         clk;
    logic         rst;
    logic         exec;
    instr_t       inst;
    data_word_t   data;
    weight_t      read_reg;
    weight_grid_t weights;

    weight_grid_t model_grid = '0;
    weight_t      exp_read = '0;
    logic         p1_valid = 1'b0;
    logic         p2_valid = 1'b0;
    instr_t       p1_inst;
    instr_t       p2_inst;
    data_word_t   p1_data;
    data_word_t   p2_data;

    logic [15:0]  lfsr_state = 16'd50;
    logic         check_en = 1'b0;
    int           error_count = 0;
    int           check_count = 0;
    int           cycle_count = 0;
    int           err_at_start;
    int           chk_at_start;

    weight_manager dut_i (
        .clk      (clk),
        .rst      (rst),
        .exec     (exec),
        .inst     (inst),
        .data     (data),
        .read_reg (read_reg),
        .weights  (weights)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random source and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle(input int n);
        exec = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic send(input wm_op_e op, input int w, input int d, input data_word_t dat);
        exec       = 1'b1;
        inst.op    = op;
        inst.w_idx = w_idx_t'(w);
        inst.d_idx = d_idx_t'(d);
        data       = dat;
        next_cycle();
    endtask

    task automatic begin_test();
        err_at_start = error_count;
        chk_at_start = check_count;
    endtask

    task automatic end_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name,
                 check_count - chk_at_start, error_count - err_at_start);
    endtask

    task automatic expect_cell(input int w, input int d, input int value);
        check_count++;
        assert (weights[w][d] == weight_t'(value)) else begin
            error_count++;
            $display("** Error at %0t: weight [%0d][%0d] is %0d, expected %0d",
                     $time, w, d, weights[w][d], value);
        end
    endtask

    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic apply_cmd(input instr_t ci, input data_word_t cd);
        int         s;
        int         v;
        logic [1:0] code;
        if (ci.op == op_load) begin
            model_grid[ci.w_idx][ci.d_idx] = weight_t'(cd[WB-1:0]);
        end else begin
            for (int r = 0; r < W; r++) begin
                code = cd[2*r +: 2];
                case (code)
                    2'b01:   s = 1;
                    2'b11:   s = -1;
                    default: s = 0;
                endcase
                v = int'(model_grid[r][ci.d_idx]) + s;
                if (v > WMAX) begin
                    v = WMAX;
                end
                if (v < WMIN) begin
                    v = WMIN;
                end
                model_grid[r][ci.d_idx] = weight_t'(v);
            end
        end
    endtask

    // A strobe seen at edge t is applied at edge t+2
    // The read uses the grid before the update
    always @(posedge clk) begin
        cycle_count++;
        if (rst) begin
            model_grid = '0;
            exp_read   = '0;
            p1_valid   = 1'b0;
            p2_valid   = 1'b0;
        end else begin
            exp_read = model_grid[inst.w_idx][inst.d_idx];
            if (p2_valid) begin
                apply_cmd(p2_inst, p2_data);
            end
            p2_valid = p1_valid;
            p2_inst  = p1_inst;
            p2_data  = p1_data;
            p1_valid = exec;
            p1_inst  = inst;
            p1_data  = data;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (check_en) begin
            check_count += 2;
            assert (weights === model_grid) else begin
                error_count++;
                $display("** Error at %0t: weights output differs from the model", $time);
            end
            assert (read_reg === exp_read) else begin
                error_count++;
                $display("** Error at %0t: read_reg is %0d, expected %0d",
                         $time, read_reg, exp_read);
            end
        end
    end

    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [63:0] v;
        logic [63:0] b;
        logic [63:0] dw;
        rst  = 1'b1;
        exec = 1'b0;
        inst = '0;
        data = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;

        begin_test();
        for (int w = 0; w < W; w++) begin
            for (int d = 0; d < D; d++) begin
                expect_cell(w, d, 0);
            end
        end
        check_count++;
        assert (read_reg == '0) else begin
            error_count++;
            $display("** Error at %0t: read_reg is %0d after reset", $time, read_reg);
        end
        check_en = 1'b1;
        idle(2);
        end_test("reset");

        begin_test();
        for (int w = 0; w < W; w++) begin
            for (int d = 0; d < D; d++) begin
                take_bits(2 * W, v);
                send(op_load, w, d, data_word_t'(v));
                idle(2);
            end
        end
        idle(4);
        for (int w = 0; w < W; w++) begin
            for (int d = 0; d < D; d++) begin
                inst.w_idx = w_idx_t'(w);
                inst.d_idx = d_idx_t'(d);
                next_cycle();
            end
        end
        idle(2);
        end_test("load_and_read");

        // Random codes over 16 rows hit the reserved code too
        begin_test();
        for (int i = 0; i < INC_ROUNDS; i++) begin
            take_bits($clog2(D), b);
            take_bits(2 * W, v);
            send(op_increment, 0, int'(b), data_word_t'(v));
            idle(3);
        end
        end_test("increment");

        begin_test();
        for (int w = 0; w < W; w++) begin
            send(op_load, w, 2, data_word_t'(WMAX));
            send(op_load, w, 5, data_word_t'(WMIN));
        end
        for (int i = 0; i < 3; i++) begin
            send(op_increment, 0, 2, {W{2'b01}});
            send(op_increment, 0, 5, {W{2'b11}});
        end
        idle(4);
        for (int w = 0; w < W; w++) begin
            expect_cell(w, 2, WMAX);
            expect_cell(w, 5, WMIN);
        end
        end_test("saturation");

        // Two columns only, so commands in flight often meet the same cells
        begin_test();
        for (int i = 0; i < B2B_CMDS; i++) begin
            take_bits(1, b);
            take_bits($clog2(W) + 1, v);
            take_bits(2 * W, dw);
            send(wm_op_e'(b[0]), int'(v[$clog2(W):1]), int'(v[0]), data_word_t'(dw));
        end
        idle(4);
        end_test("back_to_back");

        check_en = 1'b0;
        $display("tests 5, checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- weight_manager.sv
`timescale 1ns/1ps
`include "wm_cfg.svh"

module weight_manager (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         exec,
    input  wm_instr_pkg::instr_t         inst,
    input  wm_types_pkg::data_word_t     data,
    output wm_types_pkg::weight_t        read_reg,
    output wm_types_pkg::weight_grid_t   weights
);

    import wm_instr_pkg::*;

    wm_cmd_t                cmd;
    logic [`WM_WIDTH-1:0]   row_sel;

    // Decode
    // ~~~~~~~~~~~~~~~~~~~~

    wm_instr_decode decode_i (
        .clk     (clk),
        .rst     (rst),
        .exec    (exec),
        .inst    (inst),
        .data    (data),
        .cmd     (cmd),
        .row_sel (row_sel)
    );

    // Row array
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar r = 0; r < `WM_WIDTH; r++) begin : row_i
        wm_weight_row wr (
            .clk    (clk),
            .rst    (rst),
            .cmd    (cmd),
            .row_en (row_sel[r]),
            .step   (cmd.steps[r]),
            .row    (weights[r])
        );
    end

    // Read port follows the live instruction indices
    wm_read_port read_i (
        .clk      (clk),
        .rst      (rst),
        .grid     (weights),
        .w_idx    (inst.w_idx),
        .d_idx    (inst.d_idx),
        .read_reg (read_reg)
    );

endmodule

//--- wm_cfg.svh
`ifndef WM_CFG_SVH
`define WM_CFG_SVH

// Grid geometry
// ~~~~~~~~~~~~~~~~~~~~

// Rows of the grid, one per w index
`define WM_WIDTH 16

// Columns of the grid, one per d index
`define WM_DEPTH 8

// Signed bits per stored weight
`define WM_BITWIDTH 8

`endif

//--- wm_instr_decode.sv
`timescale 1ns/1ps
`include "wm_cfg.svh"

module wm_instr_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       exec,
    input  wm_instr_pkg::instr_t       inst,
    input  wm_types_pkg::data_word_t   data,
    output wm_instr_pkg::wm_cmd_t      cmd,
    output logic [`WM_WIDTH-1:0]       row_sel
);

    import wm_types_pkg::*;
    import wm_instr_pkg::*;

    localparam int WB = $bits(weight_t);

    logic                     cap_valid;
    instr_t                   cap_inst;
    data_word_t               cap_data;
    step_t [`WM_WIDTH-1:0]    clean_steps;
    logic [`WM_WIDTH-1:0]     sel_next;

    // Capture stage, the strobe is sampled here
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= exec;
            if (exec) begin
                cap_inst <= inst;
                cap_data <= data;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `WM_WIDTH; r++) begin
            clean_steps[r] = (cap_data[2*r +: 2] == 2'b10) ? 2'sb00 : step_t'(cap_data[2*r +: 2]);
        end
        // An increment touches the chosen column in every row
        if (cap_inst.op == op_increment) begin
            sel_next = '1;
        end else begin
            sel_next = `WM_WIDTH'(1) << cap_inst.w_idx;
        end
    end

    // Command stage
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.valid <= 1'b0;
            row_sel   <= '0;
        end else begin
            cmd.valid <= cap_valid;
            if (cap_valid) begin
                cmd.op         <= cap_inst.op;
                cmd.w_idx      <= cap_inst.w_idx;
                cmd.d_idx      <= cap_inst.d_idx;
                cmd.load_value <= weight_t'(cap_data[WB-1:0]);
                cmd.steps      <= clean_steps;
                row_sel        <= sel_next;
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !cmd.valid)
        else $error("command valid in the cycle after reset");

    a_load_one_row: assert property (@(posedge clk) disable iff (rst)
        (cmd.valid && cmd.op == op_load) |-> $onehot(row_sel))
        else $error("load command selects other than exactly one row");

endmodule

//--- wm_instr_pkg.sv
`include "wm_cfg.svh"

package wm_instr_pkg;

    import wm_types_pkg::*;

    // Instruction word
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        op_load      = 1'b0,
        op_increment = 1'b1
    } wm_op_e;

    // Opcode sits in the top bit, d index in the low bits
    typedef struct packed {
        wm_op_e op;
        w_idx_t w_idx;
        d_idx_t d_idx;
    } instr_t;

    // Decoded command
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                     valid;
        wm_op_e                   op;
        w_idx_t                   w_idx;
        d_idx_t                   d_idx;
        weight_t                  load_value;
        step_t [`WM_WIDTH-1:0]    steps;
    } wm_cmd_t;

endpackage

//--- wm_read_port.sv
`timescale 1ns/1ps

module wm_read_port (
    input  logic                         clk,
    input  logic                         rst,
    input  wm_types_pkg::weight_grid_t   grid,
    input  wm_types_pkg::w_idx_t         w_idx,
    input  wm_types_pkg::d_idx_t         d_idx,
    output wm_types_pkg::weight_t        read_reg
);

    import wm_types_pkg::*;

    row_weights_t sel_row;
    weight_t      sel_weight;

    // Row first, then the column within it
    always_comb begin
        sel_row    = grid[w_idx];
        sel_weight = sel_row[d_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_reg <= '0;
        end else begin
            read_reg <= sel_weight;
        end
    end

endmodule

//--- wm_types_pkg.sv
`include "wm_cfg.svh"

package wm_types_pkg;

    // Scalars
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic signed [`WM_BITWIDTH-1:0] weight_t;

    typedef logic [$clog2(`WM_WIDTH)-1:0] w_idx_t;
    typedef logic [$clog2(`WM_DEPTH)-1:0] d_idx_t;

    // Ternary step code, 2'b10 is reserved and acts as zero
    typedef logic signed [1:0] step_t;

    // Data input, load value in the low bits or one step per row
    typedef logic [2*`WM_WIDTH-1:0] data_word_t;

    // Aggregates
    // ~~~~~~~~~~~~~~~~~~~~

    typedef weight_t [`WM_DEPTH-1:0] row_weights_t;

    // Index [w][d] selects a single weight
    typedef row_weights_t [`WM_WIDTH-1:0] weight_grid_t;

endpackage

//--- wm_weight_row.sv
`timescale 1ns/1ps
`include "wm_cfg.svh"

module wm_weight_row (
    input  logic                         clk,
    input  logic                         rst,
    input  wm_instr_pkg::wm_cmd_t        cmd,
    input  logic                         row_en,
    input  wm_types_pkg::step_t          step,
    output wm_types_pkg::row_weights_t   row
);

    import wm_types_pkg::*;
    import wm_instr_pkg::*;

    localparam int WB = $bits(weight_t);

    weight_t               cur;
    logic signed [WB:0]    sum;
    weight_t               sat;
    weight_t               next_weight;

    // Saturating add
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        cur = row[cmd.d_idx];
        // One extra bit holds the carry, so the sum never wraps
        sum = cur + step;
        if (sum[WB] != sum[WB-1]) begin
            // Clamp toward the sign of the true result
            sat = {sum[WB], {(WB-1){~sum[WB]}}};
        end else begin
            sat = sum[WB-1:0];
        end
        if (cmd.op == op_load) begin
            next_weight = cmd.load_value;
        end else begin
            next_weight = sat;
        end
    end

    // Storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            row <= '0;
        end else if (cmd.valid && row_en) begin
            row[cmd.d_idx] <= next_weight;
        end
    end

    // Only the addressed column may move on an update
    for (genvar c = 0; c < `WM_DEPTH; c++) begin : col_chk
        a_other_col_stable: assert property (@(posedge clk) disable iff (rst)
            (cmd.valid && row_en && cmd.d_idx != d_idx_t'(c)) |=> $stable(row[c]))
            else $error("column %0d changed while column %0d was updated", c, $past(cmd.d_idx));
    end

endmodule
